/* mem_ctrl_vectors.txt */
// columns: op address store_data pause_mask, all hex
// op 1 fetch, 2 load, 3 store, 4 fetch and load together; mask bit n pulls rdy_in low n cycles in
1 00000010 00000000 0000
2 00000024 00000000 0000
3 00000030 a1b2c3d4 0000
2 00000030 00000000 0000
1 00000030 00000000 0000
4 00000040 00000000 0000
1 00000013 00000000 0000
2 000000fe 00000000 0000
1 00000050 00000000 0001
2 00000058 00000000 0018
1 0000005c 00000000 0050
3 00000060 0badf00d 0008
3 00000064 cafe1234 0036
2 00000060 00000000 0000
2 00000064 00000000 00a4
4 00000070 00000000 0122
4 00000084 00000000 0f00
3 000000c1 13579bdf 0014
2 000000c1 00000000 0006

/* sim.f */
mem_ctrl_pkg.sv
mem_req_if.sv
mem_rsp_if.sv
mem_req_arbiter.sv
mem_byte_sequencer.sv
mem_line_assembler.sv
mem_ctrl_top.sv
tb_mem_ctrl.sv

/* tb_mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl;

  localparam int CLK_PERIOD  = 100;
  localparam int RST_CYCLES  = 5;
  localparam int MEM_DEPTH   = 256;
  localparam int MAX_VEC     = 64;
  localparam int TEST_CYCLES = 30;
  localparam int WD_CYCLES   = 40;
  localparam int OP_FETCH    = 1;
  localparam int OP_LOAD     = 2;
  localparam int OP_STORE    = 3;
  localparam int OP_BOTH     = 4;

  logic        clk_in;
  logic        rst_in;
  logic        rdy_in;
  logic [7:0]  mem_din;
  logic [7:0]  mem_dout;
  logic [31:0] mem_a;
  logic        mem_wr;
  logic        icache_valid;
  logic [31:0] icache_addr;
  logic        icache_ready;
  logic [31:0] icache_line;
  logic        dcache_valid;
  logic        dcache_write;
  logic [31:0] dcache_addr;
  logic [31:0] dcache_wdata;
  logic        dcache_ready;
  logic [31:0] dcache_rdata;

  logic [7:0]  ram [0:MEM_DEPTH-1];
  logic [7:0]  ref_mem [0:MEM_DEPTH-1];
  logic [31:0] vec_words [0:4*MAX_VEC-1];
  logic [7:0]  rd_idx;
  int          seed;
  int          n_vec;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  bit          vec_loaded = 1'b0;

  mem_ctrl_top dut_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .mem_din      (mem_din),
    .mem_dout     (mem_dout),
    .mem_a        (mem_a),
    .mem_wr       (mem_wr),
    .icache_valid (icache_valid),
    .icache_addr  (icache_addr),
    .icache_ready (icache_ready),
    .icache_line  (icache_line),
    .dcache_valid (dcache_valid),
    .dcache_write (dcache_write),
    .dcache_addr  (dcache_addr),
    .dcache_wdata (dcache_wdata),
    .dcache_ready (dcache_ready),
    .dcache_rdata (dcache_rdata)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  // byte RAM, read data one cycle after the address
  always @(negedge clk_in) begin
    mem_din = ram[rd_idx];
    #1;
    if (mem_wr === 1'b1) begin
      ram[mem_a[7:0]] = mem_dout;
    end
    rd_idx = mem_a[7:0];
    if (rdy_in === 1'b0) begin
      assert (mem_wr === 1'b0) else begin
        $display("ERROR mem_wr while rdy_in low: got %h expected %h", mem_wr, 1'b0);
        err_cnt++;
      end
    end
  end

  initial begin
    wait (vec_loaded);
    #((RST_CYCLES + 4 + (n_vec + 1) * WD_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before all vectors finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // little-endian line from the reference copy
  function automatic logic [31:0] expected_line(input logic [31:0] addr);
    logic [31:0] line;
    int          b;
    for (b = 0; b < 4; b++) begin
      line[8*b +: 8] = ref_mem[(addr + b) % MEM_DEPTH];
    end
    return line;
  endfunction

  function automatic string op_name(input int op);
    case (op)
      OP_FETCH: return "fetch";
      OP_LOAD:  return "load";
      OP_STORE: return "store";
      default:  return "fetch+load";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string what, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: pass", what);
    end else begin
      fail_cnt++;
      $display("%s: FAIL", what);
    end
  endtask

  task automatic run_vector(input int idx, input int op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [15:0] mask);
    logic        want_i;
    logic        want_d;
    int          errs_before;
    int          cyc;
    int          i_cnt;
    int          d_cnt;
    int          i_cyc;
    int          d_cyc;
    int          b;
    logic [31:0] i_line;
    logic [31:0] d_line;
    errs_before = err_cnt;
    want_i = (op == OP_FETCH) || (op == OP_BOTH);
    want_d = (op != OP_FETCH);
    cyc = 0;
    i_cnt = 0;
    d_cnt = 0;
    i_cyc = 0;
    d_cyc = 0;
    @(negedge clk_in);
    icache_valid = want_i;
    icache_addr  = addr;
    dcache_valid = want_d;
    dcache_write = (op == OP_STORE);
    dcache_addr  = addr;
    dcache_wdata = wdata;
    rdy_in       = !mask[0];
    while (cyc < TEST_CYCLES && ((want_i && i_cnt == 0) || (want_d && d_cnt == 0))) begin
      @(negedge clk_in);
      cyc++;
      if (icache_ready === 1'b1) begin
        i_cnt++;
        i_line = icache_line;
        i_cyc = cyc;
        icache_valid = 1'b0;
      end
      if (dcache_ready === 1'b1) begin
        d_cnt++;
        d_line = dcache_rdata;
        d_cyc = cyc;
        dcache_valid = 1'b0;
        dcache_write = 1'b0;
      end
      rdy_in = (cyc < 16) ? !mask[cyc] : 1'b1;
    end
    rdy_in = 1'b1;
    icache_valid = 1'b0;
    dcache_valid = 1'b0;
    dcache_write = 1'b0;
    assert ((!want_i || i_cnt > 0) && (!want_d || d_cnt > 0)) else begin
      $display("vector %0d got no ready pulse within %0d cycles", idx, TEST_CYCLES);
      err_cnt++;
    end
    // extra pulses after completion
    repeat (3) begin
      @(negedge clk_in);
      if (icache_ready === 1'b1) i_cnt++;
      if (dcache_ready === 1'b1) d_cnt++;
    end
    check_value("icache_ready pulse count", i_cnt, want_i);
    check_value("dcache_ready pulse count", d_cnt, want_d);
    if (want_i && i_cnt > 0) check_value("icache_line", i_line, expected_line(addr));
    if (want_d && op != OP_STORE && d_cnt > 0) begin
      check_value("dcache_rdata", d_line, expected_line(addr));
    end
    if (op == OP_STORE) begin
      for (b = 0; b < 4; b++) begin
        check_value("ram byte", ram[(addr + b) % MEM_DEPTH], wdata[8*b +: 8]);
        ref_mem[(addr + b) % MEM_DEPTH] = wdata[8*b +: 8];
      end
    end
    if (op == OP_BOTH) begin
      assert (d_cyc < i_cyc) else begin
        $display("vector %0d: dcache_ready did not come before icache_ready", idx);
        err_cnt++;
      end
    end
    // unpaused single requests have a fixed latency
    if (mask == 16'h0 && op != OP_BOTH) begin
      check_value("ready latency", want_i ? i_cyc : d_cyc, (op == OP_STORE) ? 6 : 7);
    end
    report_test($sformatf("vector %0d %s addr %h", idx, op_name(op), addr), errs_before);
  endtask

  initial begin
    int errs_before;
    int i;
    rst_in       = 1'b1;
    rdy_in       = 1'b1;
    mem_din      = 8'h00;
    rd_idx       = 8'h00;
    icache_valid = 1'b0;
    icache_addr  = 32'h0;
    dcache_valid = 1'b0;
    dcache_write = 1'b0;
    dcache_addr  = 32'h0;
    dcache_wdata = 32'h0;
    err_cnt      = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    seed         = 32'h4518;
    for (i = 0; i < MEM_DEPTH; i++) begin
      ram[i] = $random(seed);
      ref_mem[i] = ram[i];
    end
    $readmemh("mem_ctrl_vectors.txt", vec_words);
    n_vec = 0;
    while (n_vec < MAX_VEC && ^vec_words[4*n_vec] !== 1'bx) n_vec++;
    vec_loaded = 1'b1;

    repeat (RST_CYCLES) @(negedge clk_in);
    rst_in = 1'b0;
    errs_before = err_cnt;
    repeat (2) begin
      @(negedge clk_in);
      check_value("icache_ready after reset", icache_ready, 1'b0);
      check_value("dcache_ready after reset", dcache_ready, 1'b0);
      check_value("mem_wr after reset", mem_wr, 1'b0);
    end
    report_test("reset", errs_before);

    for (i = 0; i < n_vec; i++) begin
      run_vector(i, vec_words[4*i], vec_words[4*i+1], vec_words[4*i+2],
                 vec_words[4*i+3][15:0]);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mem_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top import mem_ctrl_pkg::*; (
  input  wire        clk_in,
  input  wire        rst_in,
  input  wire        rdy_in,

  // RAM bus
  input  wire byte_t mem_din,
  output byte_t      mem_dout,
  output addr_t      mem_a,
  output logic       mem_wr,

  // instruction cache port
  input  wire        icache_valid,
  input  wire addr_t icache_addr,
  output logic       icache_ready,
  output line_t      icache_line,

  // data cache port
  input  wire        dcache_valid,
  input  wire        dcache_write,
  input  wire addr_t dcache_addr,
  input  wire line_t dcache_wdata,
  output logic       dcache_ready,
  output line_t      dcache_rdata
);

  logic dcache_write_ready;
  logic dcache_read_ready;
  logic line_done;

  mem_req_if req_bus ();
  mem_rsp_if rsp_bus ();

  // only one request in flight, so these never overlap
  assign dcache_ready = dcache_write_ready | dcache_read_ready;

  mem_req_arbiter arbiter_i (
    .clk_in             (clk_in),
    .rst_in             (rst_in),
    .icache_valid       (icache_valid),
    .icache_addr        (icache_addr),
    .dcache_valid       (dcache_valid),
    .dcache_write       (dcache_write),
    .dcache_addr        (dcache_addr),
    .dcache_wdata       (dcache_wdata),
    .line_done          (line_done),
    .dcache_write_ready (dcache_write_ready),
    .req                (req_bus.arbiter)
  );

  mem_byte_sequencer sequencer_i (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rdy_in   (rdy_in),
    .mem_din  (mem_din),
    .mem_dout (mem_dout),
    .mem_a    (mem_a),
    .mem_wr   (mem_wr),
    .req      (req_bus.sequencer),
    .rsp      (rsp_bus.sequencer)
  );

  mem_line_assembler assembler_i (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .icache_ready      (icache_ready),
    .icache_line       (icache_line),
    .dcache_read_ready (dcache_read_ready),
    .dcache_rdata      (dcache_rdata),
    .line_done         (line_done),
    .rsp               (rsp_bus.assembler)
  );

endmodule

`default_nettype wire

/* mem_line_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_line_assembler import mem_ctrl_pkg::*; (
  input  wire   clk_in,
  input  wire   rst_in,
  output logic  icache_ready,
  output line_t icache_line,
  output logic  dcache_read_ready,
  output line_t dcache_rdata,
  output logic  line_done,
  mem_rsp_if.assembler rsp
);

  line_t line_q;
  logic  done_q;
  port_t done_port_q;
  logic  last_byte;

  assign last_byte = rsp.byte_valid && (rsp.byte_idx == LAST_BYTE_IDX);

  // one line register feeds both ports and only the ready is steered
  assign icache_line       = line_q;
  assign dcache_rdata      = line_q;
  assign icache_ready      = done_q && (done_port_q == port_icache);
  assign dcache_read_ready = done_q && (done_port_q == port_dcache);
  assign line_done         = done_q;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      done_q <= 1'b0;
    end else begin
      done_q <= last_byte;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rsp.byte_valid) begin
      line_q[rsp.byte_idx * BYTE_W +: BYTE_W] <= rsp.byte_data;
    end
    if (last_byte) begin
      done_port_q <= rsp.rsp_port;
    end
  end

  // no new byte lands in the line while it is delivered
  a_line_stable: assert property (
    @(posedge clk_in) disable iff (rst_in)
    line_done |-> !rsp.byte_valid
  );

  // delivery is a single-cycle pulse
  a_done_pulse: assert property (
    @(posedge clk_in) disable iff (rst_in)
    line_done |=> !line_done
  );

endmodule

`default_nettype wire

/* mem_byte_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_byte_sequencer import mem_ctrl_pkg::*; (
  input  wire        clk_in,
  input  wire        rst_in,
  input  wire        rdy_in,
  input  wire byte_t mem_din,
  output byte_t      mem_dout,
  output addr_t      mem_a,
  output logic       mem_wr,
  mem_req_if.sequencer req,
  mem_rsp_if.sequencer rsp
);

  seq_state_t state_q;
  byte_idx_t  cnt_q;
  byte_idx_t  rcv_q;
  logic       pend_q;
  logic       held_q;
  byte_t      held_byte_q;
  logic       write_done_q;
  addr_t      base_q;
  line_t      wdata_q;
  port_t      port_q;
  logic       accept;
  logic       rsp_valid;

  assign accept = (state_q == seq_idle) && req.req_valid && rdy_in;

  // pend_q set when an address went out last cycle
  // held_q set when that byte arrived during a pause
  assign rsp_valid = rdy_in && (pend_q || held_q);

  assign req.req_accept = accept;
  assign req.write_done = write_done_q;

  assign rsp.byte_valid = rsp_valid;
  assign rsp.byte_idx   = rcv_q;
  assign rsp.byte_data  = held_q ? held_byte_q : mem_din;
  assign rsp.rsp_port   = port_q;

  assign mem_a    = base_q + addr_t'(cnt_q);
  assign mem_dout = wdata_q[cnt_q * BYTE_W +: BYTE_W];
  assign mem_wr   = (state_q == seq_write) && rdy_in;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q      <= seq_idle;
      cnt_q        <= '0;
      rcv_q        <= '0;
      pend_q       <= 1'b0;
      held_q       <= 1'b0;
      write_done_q <= 1'b0;
    end else begin
      write_done_q <= 1'b0;
      pend_q       <= rdy_in && (state_q == seq_read);
      if (rdy_in) begin
        held_q <= 1'b0;
      end else if (pend_q) begin
        held_q <= 1'b1;
      end
      if (rsp_valid) begin
        rcv_q <= rcv_q + 1'b1;
      end
      // everything below is frozen while the bus pauses
      if (rdy_in) begin
        case (state_q)
          seq_idle: begin
            if (accept) begin
              cnt_q   <= '0;
              rcv_q   <= '0;
              state_q <= req.req_write ? seq_write : seq_read;
            end
          end
          seq_read: begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == LAST_BYTE_IDX) begin
              state_q <= seq_drain;
            end
          end
          seq_drain: begin
            // wait for the closing byte to come back
            if (rsp_valid && rcv_q == LAST_BYTE_IDX) begin
              state_q <= seq_idle;
            end
          end
          seq_write: begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == LAST_BYTE_IDX) begin
              state_q      <= seq_idle;
              write_done_q <= 1'b1;
            end
          end
          default: begin
            state_q <= seq_idle;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      base_q  <= req.req_addr;
      wdata_q <= req.req_wdata;
      port_q  <= req.req_port;
    end
    if (pend_q && !rdy_in) begin
      held_byte_q <= mem_din;
    end
  end

  // a write never overlaps a read byte still in flight
  a_wr_no_read_in_flight: assert property (
    @(posedge clk_in) disable iff (rst_in)
    mem_wr |-> !pend_q && !held_q
  );

endmodule

`default_nettype wire

/* mem_req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_req_arbiter import mem_ctrl_pkg::*; (
  input  wire        clk_in,
  input  wire        rst_in,
  input  wire        icache_valid,
  input  wire addr_t icache_addr,
  input  wire        dcache_valid,
  input  wire        dcache_write,
  input  wire addr_t dcache_addr,
  input  wire line_t dcache_wdata,
  input  wire        line_done,
  output logic       dcache_write_ready,
  mem_req_if.arbiter req
);

  logic  busy_q;
  logic  req_valid_q;
  port_t req_port_q;
  logic  req_write_q;
  addr_t req_addr_q;
  line_t req_wdata_q;
  logic  finish;

  // writes end on write_done and reads on line_done
  assign finish             = busy_q && (req.write_done || line_done);
  assign dcache_write_ready = busy_q && req.write_done;

  assign req.req_valid = req_valid_q;
  assign req.req_port  = req_port_q;
  assign req.req_write = req_write_q;
  assign req.req_addr  = req_addr_q;
  assign req.req_wdata = req_wdata_q;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q      <= 1'b0;
      req_valid_q <= 1'b0;
    end else if (!busy_q) begin
      if (dcache_valid || icache_valid) begin
        busy_q      <= 1'b1;
        req_valid_q <= 1'b1;
      end
    end else begin
      if (req.req_accept) begin
        req_valid_q <= 1'b0;
      end
      if (finish) begin
        busy_q <= 1'b0;
      end
    end
  end

  // data port wins and the fields stay frozen while busy
  always_ff @(posedge clk_in) begin
    if (!busy_q) begin
      if (dcache_valid) begin
        req_port_q  <= port_dcache;
        req_write_q <= dcache_write;
        req_addr_q  <= dcache_addr;
        req_wdata_q <= dcache_wdata;
      end else begin
        req_port_q  <= port_icache;
        req_write_q <= 1'b0;
        req_addr_q  <= icache_addr;
        req_wdata_q <= '0;
      end
    end
  end

  // completion only ever closes the single granted request
  a_one_outstanding: assert property (
    @(posedge clk_in) disable iff (rst_in)
    (req.write_done || line_done) |-> (busy_q && !req_valid_q)
  );

  // the kind of completion matches the granted request
  a_done_kind: assert property (
    @(posedge clk_in) disable iff (rst_in)
    (req.write_done || line_done) |->
      (req.write_done != line_done) && (req.write_done == req_write_q)
  );

endmodule

`default_nettype wire

/* mem_rsp_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_rsp_if import mem_ctrl_pkg::*; ();

  logic      byte_valid;
  byte_idx_t byte_idx;
  byte_t     byte_data;
  port_t     rsp_port;

  modport sequencer (
    output byte_valid, byte_idx, byte_data, rsp_port
  );

  modport assembler (
    input  byte_valid, byte_idx, byte_data, rsp_port
  );

endinterface

`default_nettype wire

/* mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import mem_ctrl_pkg::*; ();

  logic  req_valid;
  port_t req_port;
  logic  req_write;
  addr_t req_addr;
  line_t req_wdata;

  // pulses back from the sequencer
  logic  req_accept;
  logic  write_done;

  modport arbiter (
    output req_valid, req_port, req_write, req_addr, req_wdata,
    input  req_accept, write_done
  );

  modport sequencer (
    input  req_valid, req_port, req_write, req_addr, req_wdata,
    output req_accept, write_done
  );

endinterface

`default_nettype wire

/* mem_ctrl_pkg.sv */
`default_nettype none

package mem_ctrl_pkg;

  // bus and line geometry
  localparam int ADDR_W     = 32;
  localparam int BYTE_W     = 8;
  localparam int LINE_BYTES = 4;
  localparam int LINE_W     = LINE_BYTES * BYTE_W;
  localparam int IDX_W      = $clog2(LINE_BYTES);

  // byte address on the RAM bus and on both cache ports
  typedef logic [ADDR_W-1:0] addr_t;

  // one byte on mem_din / mem_dout
  typedef logic [BYTE_W-1:0] byte_t;

  // little-endian line, byte 0 in bits 7:0
  typedef logic [LINE_W-1:0] line_t;

  // byte position inside a line
  typedef logic [IDX_W-1:0] byte_idx_t;

  // index of the byte that closes a line
  localparam byte_idx_t LAST_BYTE_IDX = byte_idx_t'(LINE_BYTES - 1);

  // who asked for the line
  typedef enum logic {
    port_icache = 1'b0,
    port_dcache = 1'b1
  } port_t;

  // byte sequencer FSM
  typedef enum logic [1:0] {
    seq_idle  = 2'd0,
    seq_read  = 2'd1,
    seq_drain = 2'd2,
    seq_write = 2'd3
  } seq_state_t;

endpackage

`default_nettype wire
